// ==== source/rv_pkg.sv ====
// rv_mini shared definitions
package rv_pkg;

  // data path and address width of the core.
  localparam int xlen = 32;

  // width of a register index, giving 32 architectural registers.
  localparam int reg_id_width = 5;

  // major opcodes of the four instructions the core knows.
  localparam logic [6:0] op_imm    = 7'b0010011;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  // ebreak is told apart from ecall by this funct12 value.
  localparam logic [11:0] funct12_ebreak = 12'b000000000001;

  // the only AXI response that lets execution go on.
  localparam logic [1:0] resp_okay = 2'b00;

  // I view, used by addi and by the system opcode.
  typedef struct packed {
    logic [11:0]             imm12;
    logic [reg_id_width-1:0] rs1;
    logic [2:0]              funct3;
    logic [reg_id_width-1:0] rd;
    logic [6:0]              opcode;
  } i_fmt_t;

  // U view, used by auipc.
  typedef struct packed {
    logic [19:0]             imm20;
    logic [reg_id_width-1:0] rd;
    logic [6:0]              opcode;
  } u_fmt_t;

  // J view, with the jal offset spread over four fields.
  typedef struct packed {
    logic                    imm20;
    logic [9:0]              imm10_1;
    logic                    imm11;
    logic [7:0]              imm19_12;
    logic [reg_id_width-1:0] rd;
    logic [6:0]              opcode;
  } j_fmt_t;

  // one instruction word, read through whichever view fits the opcode.
  typedef union packed {
    i_fmt_t i_fmt;
    u_fmt_t u_fmt;
    j_fmt_t j_fmt;
  } inst_t;

  // decoded fields and control flags handed to the execute stage.
  typedef struct packed {
    logic [reg_id_width-1:0] rd;
    logic [reg_id_width-1:0] rs1;
    logic [reg_id_width-1:0] rs2;
    logic [xlen-1:0]         imm;
    logic                    need_imm;
    logic                    alu_add;
    logic                    is_auipc;
    logic                    is_jal;
    logic                    is_ebreak;
    logic                    inst_not_ipl;
  } decode_t;

  // AXI4-Lite read address payload.
  typedef struct packed {
    logic [xlen-1:0] araddr;
    logic [2:0]      arprot;
  } axi_ar_t;

  // AXI4-Lite read data payload.
  typedef struct packed {
    logic [xlen-1:0] rdata;
    logic [1:0]      rresp;
  } axi_r_t;

  // commit trace entry, one per retired instruction.
  typedef struct packed {
    logic                    valid;
    logic [xlen-1:0]         pc;
    logic [reg_id_width-1:0] rd;
    logic [xlen-1:0]         wdata;
    logic                    we;
  } retire_t;

  // why the core stopped, or running while it has not.
  typedef enum logic [1:0] {
    running   = 2'd0,
    ebreak    = 2'd1,
    illegal   = 2'd2,
    bus_error = 2'd3
  } halt_cause_t;

endpackage

// ==== source/rv_fetch.sv ====
// instruction fetch over AXI4-Lite
`timescale 1ns/10ps

module rv_fetch #(
  parameter logic [rv_pkg::xlen-1:0] reset_vector
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pc_load,
  input  logic [rv_pkg::xlen-1:0] next_pc,
  input  logic                  halt,
  input  logic                  arready,
  input  logic                  rvalid,
  input  rv_pkg::axi_r_t        r,
  output logic                  arvalid,
  output rv_pkg::axi_ar_t       ar,
  output logic                  rready,
  output logic                  inst_valid,
  output rv_pkg::inst_t         inst,
  output logic [rv_pkg::xlen-1:0] pc,
  output logic                  bus_error
);

  // arprot for an unprivileged, secure instruction access.
  localparam logic [2:0] prot_inst = 3'b100;

  // address phase, data phase, then wait for the execute stage.
  typedef enum logic [1:0] {
    st_addr,
    st_data,
    st_wait
  } state_t;

  state_t state;

  // the address comes straight from the pc, which only moves in st_wait,
  // so ar is stable for as long as arvalid is up.
  assign ar.araddr = pc;
  assign ar.arprot = prot_inst;

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_addr;
      pc         <= reset_vector;
      arvalid    <= 1'b0;
      rready     <= 1'b0;
      inst_valid <= 1'b0;
      bus_error  <= 1'b0;
    end else begin
      // both pulses last a single cycle.
      inst_valid <= 1'b0;
      bus_error  <= 1'b0;
      case (state)
        st_addr: begin
          if (arvalid && arready) begin
            // address accepted, so open the data phase with rready high.
            arvalid <= 1'b0;
            rready  <= 1'b1;
            state   <= st_data;
          end else if (!arvalid && !halt) begin
            // first fetch after reset.
            arvalid <= 1'b1;
          end
        end
        st_data: begin
          if (rvalid) begin
            rready <= 1'b0;
            state  <= st_wait;
            if (r.rresp == rv_pkg::resp_okay) begin
              inst_valid <= 1'b1;
            end else begin
              // a failed fetch parks the machine in st_wait for good,
              // since execute halts and never sends pc_load.
              bus_error <= 1'b1;
            end
          end
        end
        st_wait: begin
          // the next address goes out in the cycle after execute.
          if (pc_load && !halt) begin
            pc      <= next_pc;
            arvalid <= 1'b1;
            state   <= st_addr;
          end
        end
        default: state <= st_addr;
      endcase
    end
  end

  // the instruction word is captured on the R handshake.
  always_ff @(posedge clk) begin
    if (state == st_data && rvalid) begin
      inst <= r.rdata;
    end
  end

endmodule

// ==== source/rv_decoder.sv ====
// RV32 instruction decoder
`timescale 1ns/10ps

module rv_decoder (
  input  rv_pkg::inst_t   inst,
  output rv_pkg::decode_t dec
);

  // opcode matches. the opcode sits in the same bits in every view.
  logic is_op_imm;
  logic is_op_auipc;
  logic is_op_jal;
  logic is_op_system;

  // minor field matches.
  logic funct3_000;
  logic funct12_is_ebreak;

  // recognized instructions.
  logic addi;
  logic auipc;
  logic jal;
  logic ebreak;

  // candidate immediates, one per format.
  logic [rv_pkg::xlen-1:0] i_imm;
  logic [rv_pkg::xlen-1:0] u_imm;
  logic [rv_pkg::xlen-1:0] j_imm;

  assign is_op_imm    = inst.i_fmt.opcode == rv_pkg::op_imm;
  assign is_op_auipc  = inst.i_fmt.opcode == rv_pkg::op_auipc;
  assign is_op_jal    = inst.i_fmt.opcode == rv_pkg::op_jal;
  assign is_op_system = inst.i_fmt.opcode == rv_pkg::op_system;

  assign funct3_000 = inst.i_fmt.funct3 == 3'b000;

  // funct12 occupies the imm12 slot of the I view.
  assign funct12_is_ebreak = inst.i_fmt.imm12 == rv_pkg::funct12_ebreak;

  // addi is the only op_imm variant with funct3 zero.
  assign addi   = is_op_imm & funct3_000;
  assign auipc  = is_op_auipc;
  assign jal    = is_op_jal;
  assign ebreak = is_op_system & funct3_000 & funct12_is_ebreak;

  // I immediate is the sign-extended top twelve bits.
  assign i_imm = {{(rv_pkg::xlen-12){inst.i_fmt.imm12[11]}}, inst.i_fmt.imm12};

  // U immediate fills the upper twenty bits and leaves the rest zero.
  assign u_imm = {inst.u_fmt.imm20, 12'b0};

  // J immediate is reassembled from its scattered pieces, with bit 0 always zero.
  assign j_imm = {{(rv_pkg::xlen-21){inst.j_fmt.imm20}},
                  inst.j_fmt.imm20,
                  inst.j_fmt.imm19_12,
                  inst.j_fmt.imm11,
                  inst.j_fmt.imm10_1,
                  1'b0};

  // register indices. rs2 would sit in the low five bits of imm12,
  // which is where the R format keeps it.
  assign dec.rd  = inst.i_fmt.rd;
  assign dec.rs1 = inst.i_fmt.rs1;
  assign dec.rs2 = inst.i_fmt.imm12[rv_pkg::reg_id_width-1:0];

  // the formats never overlap, so an and-or select is enough.
  // unknown encodings end up with a zero immediate.
  assign dec.imm = ({rv_pkg::xlen{addi}}  & i_imm) |
                   ({rv_pkg::xlen{auipc}} & u_imm) |
                   ({rv_pkg::xlen{jal}}   & j_imm);

  // addi and auipc both go through the adder as a plain add.
  assign dec.alu_add = addi | auipc;

  // none of the known instructions reads rs2, so all take the immediate.
  assign dec.need_imm = addi | auipc | jal;

  assign dec.is_auipc  = auipc;
  assign dec.is_jal    = jal;
  assign dec.is_ebreak = ebreak;

  // everything outside the four known instructions stops the core.
  assign dec.inst_not_ipl = ~(addi | auipc | jal | ebreak);

endmodule

// ==== source/rv_regfile.sv ====
// integer register file
`timescale 1ns/10ps

module rv_regfile (
  input  logic                             clk,
  input  logic                             reset,
  input  logic [rv_pkg::reg_id_width-1:0]  rs1,
  input  logic [rv_pkg::reg_id_width-1:0]  rs2,
  input  logic                             we,
  input  logic [rv_pkg::reg_id_width-1:0]  rd,
  input  logic [rv_pkg::xlen-1:0]          wdata,
  output logic [rv_pkg::xlen-1:0]          rs1_data,
  output logic [rv_pkg::xlen-1:0]          rs2_data
);

  // all 32 entries exist, but entry 0 is never written.
  logic [rv_pkg::xlen-1:0] regs [32];

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd != '0) begin
      // writes to x0 are dropped here.
      regs[rd] <= wdata;
    end
  end

  // reads are combinational. x0 reads as zero no matter what is stored.
  assign rs1_data = (rs1 == '0) ? '0 : regs[rs1];
  assign rs2_data = (rs2 == '0) ? '0 : regs[rs2];

endmodule

// ==== source/rv_execute.sv ====
// execute and retire stage
`timescale 1ns/10ps

module rv_execute #(
  parameter logic [rv_pkg::xlen-1:0] reset_vector
) (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      inst_valid,
  input  rv_pkg::decode_t           dec,
  input  logic [rv_pkg::xlen-1:0]   pc,
  input  logic [rv_pkg::xlen-1:0]   rs1_data,
  input  logic                      bus_error,
  output logic                      we,
  output logic [rv_pkg::xlen-1:0]   wdata,
  output logic                      pc_load,
  output logic [rv_pkg::xlen-1:0]   next_pc,
  output logic                      halt,
  output rv_pkg::halt_cause_t       halt_cause,
  output rv_pkg::retire_t           retire
);

  logic [rv_pkg::xlen-1:0] op_a;
  logic [rv_pkg::xlen-1:0] op_b;
  logic [rv_pkg::xlen-1:0] sum;
  logic [rv_pkg::xlen-1:0] pc_plus4;
  logic                    stopping;

  // auipc and jal add to the pc, addi adds to rs1.
  assign op_a = (dec.is_auipc || dec.is_jal) ? pc : rs1_data;
  assign op_b = dec.need_imm ? dec.imm : '0;

  // the single adder shared by addi, auipc and the jal target.
  assign sum = op_a + op_b;

  // link value for jal and the fall-through pc for everything else.
  assign pc_plus4 = pc + 32'd4;

  // ebreak and unknown encodings end execution at this instruction.
  assign stopping = inst_valid & (dec.is_ebreak | dec.inst_not_ipl);

  // the write-back value. jal links, the adder covers the rest.
  assign wdata = dec.is_jal ? pc_plus4 : sum;

  // writes with rd zero are suppressed so the trace never shows one.
  assign we = inst_valid & (dec.alu_add | dec.is_jal) & (dec.rd != '0);

  // a stopping instruction withholds pc_load, which keeps fetch parked.
  assign pc_load = inst_valid & ~stopping;
  assign next_pc = dec.is_jal ? sum : pc_plus4;

  // the trace entry is registered in the execute cycle, together with
  // the register write and the pc update.
  always_ff @(posedge clk) begin
    if (reset) begin
      retire.valid <= 1'b0;
      retire.pc    <= reset_vector;
      retire.rd    <= '0;
      retire.wdata <= '0;
      retire.we    <= 1'b0;
    end else begin
      retire.valid <= inst_valid;
      if (inst_valid) begin
        retire.pc    <= pc;
        retire.rd    <= dec.rd;
        retire.wdata <= wdata;
        retire.we    <= we;
      end
    end
  end

  // halt is sticky, and the first cause to arrive is the one kept.
  always_ff @(posedge clk) begin
    if (reset) begin
      halt       <= 1'b0;
      halt_cause <= rv_pkg::running;
    end else if (!halt) begin
      if (bus_error) begin
        halt       <= 1'b1;
        halt_cause <= rv_pkg::bus_error;
      end else if (inst_valid && dec.is_ebreak) begin
        halt       <= 1'b1;
        halt_cause <= rv_pkg::ebreak;
      end else if (inst_valid && dec.inst_not_ipl) begin
        halt       <= 1'b1;
        halt_cause <= rv_pkg::illegal;
      end
    end
  end

endmodule

// ==== source/rv_mini_core.sv ====
// rv_mini core top level
`timescale 1ns/10ps

module rv_mini_core #(
  parameter logic [rv_pkg::xlen-1:0] reset_vector = 32'h0000_0000
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                arready,
  input  logic                rvalid,
  input  rv_pkg::axi_r_t      r,
  output logic                arvalid,
  output rv_pkg::axi_ar_t     ar,
  output logic                rready,
  output rv_pkg::retire_t     retire,
  output logic                halt,
  output rv_pkg::halt_cause_t halt_cause
);

  // fetch to decode and execute.
  logic                      inst_valid;
  rv_pkg::inst_t             inst;
  logic [rv_pkg::xlen-1:0]   pc;
  logic                      bus_error;

  // execute back to fetch.
  logic                      pc_load;
  logic [rv_pkg::xlen-1:0]   next_pc;

  // decode result and register file traffic.
  rv_pkg::decode_t           dec;
  logic [rv_pkg::xlen-1:0]   rs1_data;
  logic                      we;
  logic [rv_pkg::xlen-1:0]   wdata;

  rv_fetch #(
    .reset_vector (reset_vector)
  ) u_fetch (
    .clk        (clk),
    .reset      (reset),
    .pc_load    (pc_load),
    .next_pc    (next_pc),
    .halt       (halt),
    .arready    (arready),
    .rvalid     (rvalid),
    .r          (r),
    .arvalid    (arvalid),
    .ar         (ar),
    .rready     (rready),
    .inst_valid (inst_valid),
    .inst       (inst),
    .pc         (pc),
    .bus_error  (bus_error)
  );

  rv_decoder u_decoder (
    .inst (inst),
    .dec  (dec)
  );

  // rs2 is indexed but nothing in the current set consumes its data.
  rv_regfile u_regfile (
    .clk      (clk),
    .reset    (reset),
    .rs1      (dec.rs1),
    .rs2      (dec.rs2),
    .we       (we),
    .rd       (dec.rd),
    .wdata    (wdata),
    .rs1_data (rs1_data),
    .rs2_data ()
  );

  rv_execute #(
    .reset_vector (reset_vector)
  ) u_execute (
    .clk        (clk),
    .reset      (reset),
    .inst_valid (inst_valid),
    .dec        (dec),
    .pc         (pc),
    .rs1_data   (rs1_data),
    .bus_error  (bus_error),
    .we         (we),
    .wdata      (wdata),
    .pc_load    (pc_load),
    .next_pc    (next_pc),
    .halt       (halt),
    .halt_cause (halt_cause),
    .retire     (retire)
  );

endmodule

// ==== test/rv_mini_properties.sv ====
// AXI read and retire assertions
`timescale 1ns/10ps

module rv_mini_properties (
  input logic            clk,
  input logic            reset,
  input logic            arvalid,
  input logic            arready,
  input rv_pkg::axi_ar_t ar,
  input logic            halt,
  input rv_pkg::retire_t retire
);

  // number of assertion failures seen so far.
  int fail_count = 0;

  // a request held off by the slave keeps both valid and payload.
  ar_held: assert property (@(posedge clk) disable iff (reset)
    (arvalid && !arready) |=> (arvalid && $stable(ar)))
    else begin
      fail_count++;
      $error("arvalid dropped or ar changed before arready");
    end

  // a halted core issues no further reads.
  no_fetch_halted: assert property (@(posedge clk) disable iff (reset)
    halt |-> !arvalid)
    else begin
      fail_count++;
      $error("arvalid is high while the core is halted");
    end

  // with one instruction in flight, retires are at least two cycles apart.
  retire_spaced: assert property (@(posedge clk) disable iff (reset)
    retire.valid |=> !retire.valid)
    else begin
      fail_count++;
      $error("retire.valid was high in two consecutive cycles");
    end

  // the trace never reports a write to x0.
  no_x0_write: assert property (@(posedge clk) disable iff (reset)
    (retire.valid && retire.we) |-> (retire.rd != '0))
    else begin
      fail_count++;
      $error("retire reports a write to x0");
    end

endmodule

bind rv_mini_core rv_mini_properties u_props (
  .clk     (clk),
  .reset   (reset),
  .arvalid (arvalid),
  .arready (arready),
  .ar      (ar),
  .halt    (halt),
  .retire  (retire)
);

// ==== test/rv_mini_tb.sv ====
// rv_mini core testbench
`timescale 1ns/10ps

module rv_mini_tb;

  localparam logic [31:0] start_pc = 32'h0000_1000;
  localparam int mem_words = 256;
  // an instruction waits at most four cycles on AR and four on R, then
  // spends one in execute and one before the next arvalid.
  localparam int max_cpi = 12;
  localparam int cycle_limit = 3 * (mem_words * max_cpi + 64);
  localparam logic [31:0] ebreak_word = 32'h0010_0073;
  // add x0, x1, x2 is a real RV32 encoding that this core does not know.
  localparam logic [31:0] add_word = 32'h0020_8033;

  logic                clk = 1'b0;
  logic                reset;
  logic                arready;
  logic                rvalid;
  rv_pkg::axi_r_t      r;
  logic                arvalid;
  rv_pkg::axi_ar_t     ar;
  logic                rready;
  rv_pkg::retire_t     retire;
  logic                halt;
  rv_pkg::halt_cause_t halt_cause;

  // program memory, and the word that answers with SLVERR (-1 for none).
  logic [31:0] mem [mem_words];
  int          err_index;

  // slave state for the single outstanding read.
  logic        pending;
  logic [31:0] req_addr;
  int          ar_delay;
  int          r_delay;

  // architectural model.
  logic [31:0] m_pc;
  logic [31:0] m_regs [32];
  logic        m_stopped;

  int errors = 0;
  int cycle_count = 0;

  rv_mini_core #(
    .reset_vector (start_pc)
  ) u_dut (
    .clk        (clk),
    .reset      (reset),
    .arready    (arready),
    .rvalid     (rvalid),
    .r          (r),
    .arvalid    (arvalid),
    .ar         (ar),
    .rready     (rready),
    .retire     (retire),
    .halt       (halt),
    .halt_cause (halt_cause)
  );

  always #4 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected) begin
      errors++;
      $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  function automatic int mem_index(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - start_pc;
    return int'(off[9:2]);
  endfunction

  // x0 is picked often enough to show that writes to it are dropped.
  function automatic logic [4:0] pick_rd();
    if ($urandom_range(0, 7) == 0) begin
      return 5'd0;
    end
    return 5'($urandom_range(1, 31));
  endfunction

  // one random addi, auipc or jal. jal only jumps forward and stays in
  // the array, so every program runs into its last word.
  function automatic logic [31:0] build_inst(input int idx);
    rv_pkg::inst_t w;
    int            kind;
    int            span;
    logic [20:0]   off;
    kind = $urandom_range(0, 9);
    w = '0;
    if (kind >= 8 && idx < mem_words - 1) begin
      span = mem_words - 1 - idx;
      if (span > 16) begin
        span = 16;
      end
      off = 21'(4 * $urandom_range(1, span));
      w.j_fmt.opcode   = rv_pkg::op_jal;
      w.j_fmt.rd       = pick_rd();
      w.j_fmt.imm20    = off[20];
      w.j_fmt.imm10_1  = off[10:1];
      w.j_fmt.imm11    = off[11];
      w.j_fmt.imm19_12 = off[19:12];
    end else if (kind >= 6) begin
      w.u_fmt.opcode = rv_pkg::op_auipc;
      w.u_fmt.rd     = pick_rd();
      w.u_fmt.imm20  = 20'($urandom);
    end else begin
      w.i_fmt.opcode = rv_pkg::op_imm;
      w.i_fmt.rd     = pick_rd();
      w.i_fmt.rs1    = 5'($urandom_range(0, 31));
      w.i_fmt.funct3 = 3'b000;
      w.i_fmt.imm12  = 12'($urandom);
    end
    return w;
  endfunction

  // AXI4-Lite read slave with 0 to 3 cycles of wait on each phase.
  always @(posedge clk) begin
    if (reset) begin
      arready  <= 1'b0;
      rvalid   <= 1'b0;
      r        <= '0;
      pending  <= 1'b0;
      ar_delay <= $urandom_range(0, 3);
      r_delay  <= 0;
    end else begin
      if (arvalid && arready) begin
        // each fetch goes to the model pc as an instruction access.
        check_value("ar.araddr", m_pc, ar.araddr);
        check_value("ar.arprot[2]", 32'd1, 32'(ar.arprot[2]));
        arready  <= 1'b0;
        pending  <= 1'b1;
        req_addr <= ar.araddr;
        r_delay  <= $urandom_range(0, 3);
      end else if (arvalid) begin
        if (ar_delay == 0) begin
          arready <= 1'b1;
        end else begin
          ar_delay <= ar_delay - 1;
        end
      end
      // the core keeps rready up for the whole data phase.
      if (rvalid) begin
        check_value("rready", 32'd1, 32'(rready));
      end
      if (rvalid && rready) begin
        rvalid   <= 1'b0;
        pending  <= 1'b0;
        ar_delay <= $urandom_range(0, 3);
      end else if (pending && !rvalid) begin
        if (r_delay == 0) begin
          rvalid  <= 1'b1;
          r.rdata <= mem[mem_index(req_addr)];
          r.rresp <= (mem_index(req_addr) == err_index) ? 2'b10 : 2'b00;
        end else begin
          r_delay <= r_delay - 1;
        end
      end
    end
  end

  // runs the instruction at the model pc and compares it with the trace.
  task automatic model_retire();
    rv_pkg::inst_t w;
    logic [31:0]   exp_wdata;
    logic [31:0]   next_pc;
    logic [31:0]   j_imm;
    logic          exp_we;
    logic          known;
    w = mem[mem_index(m_pc)];
    if (m_stopped) begin
      errors++;
      $display("an instruction retired at %0t after the core should have halted", $time);
    end
    if (mem_index(m_pc) == err_index) begin
      errors++;
      $display("an instruction retired at %0t although its fetch failed", $time);
    end
    check_value("retire.pc", m_pc, retire.pc);
    exp_wdata = '0;
    next_pc   = m_pc + 32'd4;
    known     = 1'b1;
    case (w.i_fmt.opcode)
      rv_pkg::op_imm:   exp_wdata = m_regs[w.i_fmt.rs1] +
                                    {{20{w.i_fmt.imm12[11]}}, w.i_fmt.imm12};
      rv_pkg::op_auipc: exp_wdata = m_pc + {w.u_fmt.imm20, 12'b0};
      rv_pkg::op_jal: begin
        j_imm = {{12{w.j_fmt.imm20}}, w.j_fmt.imm19_12, w.j_fmt.imm11,
                 w.j_fmt.imm10_1, 1'b0};
        exp_wdata = m_pc + 32'd4;
        next_pc   = m_pc + j_imm;
      end
      default: known = 1'b0;
    endcase
    // rd sits in the same bits for every format.
    exp_we = known && (w.i_fmt.rd != 5'd0);
    check_value("retire.rd", 32'(w.i_fmt.rd), 32'(retire.rd));
    check_value("retire.we", 32'(exp_we), 32'(retire.we));
    if (known) begin
      check_value("retire.wdata", exp_wdata, retire.wdata);
    end
    // halt rises on the same edge as the retire of a stopping instruction.
    check_value("halt", 32'(!known), 32'(halt));
    if (exp_we) begin
      m_regs[w.i_fmt.rd] = exp_wdata;
    end
    if (known) begin
      m_pc = next_pc;
    end else begin
      m_stopped = 1'b1;
    end
  endtask

  // the trace is compared at the falling edge, where it is stable.
  always @(negedge clk) begin
    if (!reset && retire.valid) begin
      model_retire();
    end
  end

  // one program from reset to halt, ending in the given cause.
  task automatic run_segment(input rv_pkg::halt_cause_t exp_cause);
    @(posedge clk);
    reset <= 1'b1;
    for (int i = 0; i < mem_words - 1; i++) begin
      mem[i] = build_inst(i);
    end
    case (exp_cause)
      rv_pkg::ebreak:  mem[mem_words-1] = ebreak_word;
      rv_pkg::illegal: mem[mem_words-1] = add_word;
      default:         mem[mem_words-1] = build_inst(mem_words - 1);
    endcase
    err_index = (exp_cause == rv_pkg::bus_error) ? mem_words - 1 : -1;
    m_pc      = start_pc;
    m_stopped = 1'b0;
    for (int i = 0; i < 32; i++) begin
      m_regs[i] = '0;
    end
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
    while (!halt) begin
      @(negedge clk);
    end
    // one more edge lets the model finish the last retire.
    @(negedge clk);
    check_value("halt_cause", 32'(exp_cause), 32'(halt_cause));
    if (exp_cause == rv_pkg::bus_error) begin
      check_value("model pc at bus error", start_pc + 32'(4 * (mem_words - 1)), m_pc);
    end else if (!m_stopped) begin
      errors++;
      $display("the core halted at %0t before its last instruction retired", $time);
    end
    repeat (10) begin
      @(negedge clk);
      if (arvalid || retire.valid) begin
        errors++;
        $display("the core fetched or retired at %0t after it halted", $time);
      end
    end
  endtask

  // a hung core ends the run here.
  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: the core did not halt within %0d cycles", cycle_limit);
      $display("errors: %0d", errors + u_dut.u_props.fail_count + 1);
      $display("test failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(12287));
    reset     = 1'b1;
    arready   = 1'b0;
    rvalid    = 1'b0;
    r         = '0;
    err_index = -1;
    run_segment(rv_pkg::ebreak);
    run_segment(rv_pkg::illegal);
    run_segment(rv_pkg::bus_error);
    errors += u_dut.u_props.fail_count;
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("test passed");
    end else begin
      $display("test failed");
    end
    $finish;
  end

endmodule

// ==== rv_mini.f ====
source/rv_pkg.sv
source/rv_fetch.sv
source/rv_decoder.sv
source/rv_regfile.sv
source/rv_execute.sv
source/rv_mini_core.sv
test/rv_mini_properties.sv
test/rv_mini_tb.sv

// ==== Bender.yml ====
package:
  name: rv_mini

sources:
  - source/rv_pkg.sv
  - source/rv_fetch.sv
  - source/rv_decoder.sv
  - source/rv_regfile.sv
  - source/rv_execute.sv
  - source/rv_mini_core.sv
  - target: test
    files:
      - test/rv_mini_properties.sv
      - test/rv_mini_tb.sv
